// ==== verilog/insPkg.sv ====
// Instruction set definitions shared by the fetch and align front end.
// Holds the first-byte opcode values, the two-byte head that sets an
// instruction's length, and the record handed out for each instruction.
// Import it inside a module body; ports name its types with insPkg::.

package insPkg;

  // ==================================================
  // Limits
  // ==================================================

  // Longest instruction in bytes, which is also the aligner window width
  localparam int maxInsLen = 8;

  // Byte count of one instruction, from 1 to maxInsLen
  typedef logic [3:0] insLen;

  // ==================================================
  // First-byte opcodes
  // ==================================================

  // Only the opcodes with a length of their own are listed here.
  // Branch groups 0x2? and 0x3? are matched on the high nibble in the
  // length decoder, and 0x8? / 0x9? only grow when the extension bit is set.
  // Keep new values clear of those four nibble ranges
  typedef enum logic [7:0] {
    BRK   = 8'h00,
    ADDI  = 8'h04,
    ANDI  = 8'h08,
    ORI   = 8'h09,
    CSR   = 8'h0F,
    ADDIL = 8'h44,
    CHKI  = 8'h45,
    BMAPI = 8'h4F,
    SYS   = 8'hC0,
    MOV   = 8'hC2,
    NOP   = 8'hF1,
    RTS   = 8'hF2
  } opcode;

  // ==================================================
  // Instruction records
  // ==================================================

  // The nine bits that decide the length.
  // v is bit 7 of the second byte and sits above the opcode, so the
  // packed value reads like the 9-bit patterns of the opcode map
  typedef struct packed {
    logic       v;
    logic [7:0] opcode;
  } insHead;

  // One aligned instruction as it leaves the front end.
  // Byte 0 of bytes is the opcode byte, in bits 7:0.
  // Bytes at or beyond len are always zero
  typedef struct packed {
    logic [31:0] addr;
    insLen       len;
    logic [63:0] bytes;
  } fetchedIns;

endpackage

// ==== verilog/busPkg.sv ====
// Wishbone classic bus records for the instruction fetch port.
// The master drives wbReq and the memory answers with wbRsp.
// Only reads are issued, so we stays low and sel covers the whole word.

package busPkg;

  // ==================================================
  // Bus widths
  // ==================================================

  localparam int wbAdrWidth = 32;
  localparam int wbDatWidth = 32;
  // One select bit per data byte
  localparam int wbSelWidth = wbDatWidth / 8;

  // Master to slave.
  // adr is a byte address and stays word aligned for fetches
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [wbAdrWidth-1:0] adr;
    logic [wbSelWidth-1:0] sel;
  } wbReq;

  // Slave to master.
  // dat is little-endian, byte 0 sits at the lowest address
  typedef struct packed {
    logic [wbDatWidth-1:0] dat;
    logic                  ack;
  } wbRsp;

endpackage

// ==== verilog/insLength.sv ====
// Length decoder for the variable-length instruction set.
// Purely combinational: give it the first two bytes as an insHead and it
// returns the byte count of that instruction, 1 to 8.

module insLength (
  input  insPkg::insHead head,
  output insPkg::insLen  len
);

  import insPkg::*;

  // ==================================================
  // Opcode to length table
  // ==================================================

  // Single opcodes come first, then the nibble groups.
  // Anything not listed is a one-byte instruction
  always_comb begin
    len = 4'd1;
    casez (head.opcode)
      // Short control instructions
      BRK:   len = 4'd2;
      NOP:   len = 4'd2;
      RTS:   len = 4'd2;
      SYS:   len = 4'd3;
      MOV:   len = 4'd3;
      // Register plus short immediate
      ADDI:  len = 4'd4;
      ANDI:  len = 4'd4;
      ORI:   len = 4'd4;
      CSR:   len = 4'd5;
      // Long immediate forms
      ADDIL: len = 4'd7;
      CHKI:  len = 4'd8;
      BMAPI: len = 4'd8;
      // Branches
      8'h2?: len = 4'd5;
      // Long branches
      8'h3?: len = 4'd7;
      // The 9-bit forms 0x18? and 0x19?.
      // With the extension bit clear these stay single bytes
      8'h8?, 8'h9?: begin
        if (head.v) begin
          len = 4'd6;
        end else begin
          len = 4'd1;
        end
      end
      default: len = 4'd1;
    endcase
  end

endmodule

// ==== verilog/byteQueue.sv ====
// Byte queue between the fetch master and the aligner.
// Takes one 32-bit word (four bytes, lowest address first) per push and
// shows the eight oldest bytes as a window. The consumer pops 0 to 8 bytes
// per cycle; push and pop can happen in the same cycle.

module byteQueue #(
  parameter int queueDepth = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          pushValid,
  input  logic [31:0]                   pushWord,
  input  insPkg::insLen                 popLen,
  output logic [63:0]                   window,
  output logic [$clog2(queueDepth):0]   count
);

  import insPkg::*;

  localparam int ptrWidth  = $clog2(queueDepth);
  localparam int cntWidth  = ptrWidth + 1;
  localparam int wordBytes = 4;

  // Depth is a power of two, so the pointers wrap on their own
  logic [7:0]          store [queueDepth];
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth-1:0] wrPtr;

  // ==================================================
  // Pointers and fill level
  // ==================================================

  // The fetch master only pushes when there is room for a full word,
  // and the aligner never pops more than count, so no checks here
  always_ff @(posedge clk) begin
    if (rst) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (pushValid) begin
        wrPtr <= wrPtr + ptrWidth'(wordBytes);
      end
      rdPtr <= rdPtr + ptrWidth'(popLen);
      count <= count + (pushValid ? cntWidth'(wordBytes) : '0) - cntWidth'(popLen);
    end
  end

  // Byte storage, written four bytes at a time in little-endian order
  always_ff @(posedge clk) begin
    if (pushValid) begin
      for (int i = 0; i < wordBytes; i++) begin
        store[wrPtr + ptrWidth'(i)] <= pushWord[8*i +: 8];
      end
    end
  end

  // ==================================================
  // Read window
  // ==================================================

  // Oldest byte in bits 7:0.
  // Slots past the fill level read as zero so stale bytes never leak out
  always_comb begin
    for (int i = 0; i < maxInsLen; i++) begin
      if (cntWidth'(i) < count) begin
        window[8*i +: 8] = store[rdPtr + ptrWidth'(i)];
      end else begin
        window[8*i +: 8] = 8'h00;
      end
    end
  end

endmodule

// ==== verilog/fetchMaster.sv ====
// Wishbone classic read master for sequential instruction fetch.
// Starts at resetAddr and reads one word at a time, advancing by four on
// each ack. Every returned word is pushed into the byte queue in the ack
// cycle. A read is only started when the queue can take the whole word.

module fetchMaster #(
  parameter logic [31:0] resetAddr  = 32'h0,
  parameter int          queueDepth = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  output busPkg::wbReq                 wbOut,
  input  busPkg::wbRsp                 wbIn,
  input  logic [$clog2(queueDepth):0]  count,
  output logic                         pushValid,
  output logic [31:0]                  pushWord
);

  import busPkg::*;

  localparam int wordBytes = wbDatWidth / 8;

  typedef enum logic [1:0] {
    stIdle,
    stRequest,
    stGap
  } fetchState;

  fetchState             state;
  logic [wbAdrWidth-1:0] fetchAdr;
  logic                  room;

  // ==================================================
  // Flow control
  // ==================================================

  // The word about to be requested is the one outstanding word.
  // Nothing else is in flight when this is looked at, and count only
  // falls until the ack, so the push at ack always fits
  assign room = (int'(count) + wordBytes) <= queueDepth;

  // ==================================================
  // Bus cycle FSM
  // ==================================================

  // stGap keeps stb low for one cycle after every ack.
  // By then the pushed word already shows in count
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= stIdle;
      fetchAdr <= resetAddr;
    end else begin
      case (state)
        stIdle: begin
          if (room) begin
            state <= stRequest;
          end
        end
        stRequest: begin
          // Request held stable until the slave acks
          if (wbIn.ack) begin
            state    <= stGap;
            fetchAdr <= fetchAdr + wbAdrWidth'(wordBytes);
          end
        end
        stGap: begin
          state <= room ? stRequest : stIdle;
        end
        default: state <= stIdle;
      endcase
    end
  end

  always_comb begin
    wbOut.cyc = (state == stRequest);
    wbOut.stb = (state == stRequest);
    wbOut.we  = 1'b0;
    wbOut.adr = fetchAdr;
    wbOut.sel = {wbSelWidth{1'b1}};
  end

  // Data is forwarded straight from the bus in the ack cycle
  assign pushValid = (state == stRequest) && wbIn.ack;
  assign pushWord  = wbIn.dat;

endmodule

// ==== verilog/insAligner.sv ====
// Instruction aligner. Decodes the length of the instruction at the front
// of the byte queue, waits until all of its bytes are there, then loads it
// into the output register and pops it from the queue in the same edge.
// The output follows valid/ready; ins is held while valid waits on ready.

module insAligner #(
  parameter logic [31:0] resetAddr  = 32'h0,
  parameter int          queueDepth = 16
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [63:0]                  window,
  input  logic [$clog2(queueDepth):0]  count,
  output insPkg::insLen                popLen,
  output logic                         insValid,
  output insPkg::fetchedIns            ins,
  input  logic                         insReady
);

  import insPkg::*;

  localparam int cntWidth = $clog2(queueDepth) + 1;

  insHead      head;
  insLen       headLen;
  logic [31:0] pc;
  logic [63:0] maskedBytes;
  logic        haveHead;
  logic        haveAll;
  logic        slotFree;
  logic        load;

  // ==================================================
  // Length of the head instruction
  // ==================================================

  // Extension bit is bit 7 of the second byte
  assign head.v      = window[15];
  assign head.opcode = window[7:0];

  insLength lenDec (
    .head (head),
    .len  (headLen)
  );

  // Byte 1 must be real before the length can be trusted.
  // An empty second slot reads as zero and would clear the extension bit
  assign haveHead = count >= cntWidth'(2);
  assign haveAll  = count >= cntWidth'(headLen);
  // The register is free if empty or handing its value over this cycle
  assign slotFree = !insValid || insReady;
  assign load     = haveHead && haveAll && slotFree;
  assign popLen   = load ? headLen : '0;

  // Clear every byte past the instruction end
  always_comb begin
    for (int i = 0; i < maxInsLen; i++) begin
      maskedBytes[8*i +: 8] = (i < int'(headLen)) ? window[8*i +: 8] : 8'h00;
    end
  end

  // ==================================================
  // Output register
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      insValid <= 1'b0;
      pc       <= resetAddr;
    end else if (load) begin
      insValid <= 1'b1;
      pc       <= pc + 32'(headLen);
    end else if (insReady) begin
      insValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      ins <= '{addr: pc, len: headLen, bytes: maskedBytes};
    end
  end

endmodule

// ==== verilog/insFetchTop.sv ====
// Instruction fetch and align front end.
// Connect wbOut/wbIn to a Wishbone classic memory holding the program;
// aligned instructions come out on ins under insValid/insReady, in program
// order starting at resetAddr.

module insFetchTop #(
  parameter logic [31:0] resetAddr  = 32'h0,
  parameter int          queueDepth = 16
) (
  input  logic              clk,
  input  logic              rst,
  output busPkg::wbReq      wbOut,
  input  busPkg::wbRsp      wbIn,
  output logic              insValid,
  output insPkg::fetchedIns ins,
  input  logic              insReady
);

  import insPkg::*;

  localparam int cntWidth = $clog2(queueDepth) + 1;

  // Fetch master to queue
  logic                pushValid;
  logic [31:0]         pushWord;
  // Queue to aligner and back
  logic [63:0]         window;
  logic [cntWidth-1:0] count;
  insLen               popLen;

  fetchMaster #(
    .resetAddr  (resetAddr),
    .queueDepth (queueDepth)
  ) fetch (
    .clk       (clk),
    .rst       (rst),
    .wbOut     (wbOut),
    .wbIn      (wbIn),
    .count     (count),
    .pushValid (pushValid),
    .pushWord  (pushWord)
  );

  byteQueue #(
    .queueDepth (queueDepth)
  ) queue (
    .clk       (clk),
    .rst       (rst),
    .pushValid (pushValid),
    .pushWord  (pushWord),
    .popLen    (popLen),
    .window    (window),
    .count     (count)
  );

  // The aligner only needs queueDepth to size its count input
  insAligner #(
    .resetAddr  (resetAddr),
    .queueDepth (queueDepth)
  ) align (
    .clk      (clk),
    .rst      (rst),
    .window   (window),
    .count    (count),
    .popLen   (popLen),
    .insValid (insValid),
    .ins      (ins),
    .insReady (insReady)
  );

endmodule

// ==== bench/insMemModel.sv ====
// Wishbone classic slave memory for the fetch testbench.
// The testbench fills it through loadWord before reset is released.
// Each read is acked after 0 to 3 random wait cycles, and every acked
// address is kept in accessLog for the address order check.

module insMemModel #(
  parameter int numWords = 256
) (
  input  logic         clk,
  input  logic         rst,
  input  busPkg::wbReq req,
  output busPkg::wbRsp rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  import busPkg::*;

  localparam int idxWidth = $clog2(numWords);

  logic [31:0] words [numWords];
  logic [31:0] accessLog [$];
  logic        pending;
  int          waitLeft;

  task automatic loadWord(input int idx, input logic [31:0] data);
    words[idx] = data;
  endtask

  // ==================================================
  // Read response
  // ==================================================

  // The wait count is drawn on the first cycle of a request.
  // Addresses past the end wrap, so the image repeats every numWords words
  always @(posedge clk) begin
    int waitNow;
    if (rst) begin
      rsp      <= '0;
      pending  <= 1'b0;
      waitLeft <= 0;
    end else begin
      rsp.ack <= 1'b0;
      // The master drops stb after the ack cycle, so skip that cycle
      if (req.cyc && req.stb && !rsp.ack) begin
        waitNow = pending ? waitLeft : int'($urandom_range(3, 0));
        if (waitNow == 0) begin
          rsp.ack <= 1'b1;
          rsp.dat <= words[req.adr[idxWidth+1:2]];
          accessLog.push_back(req.adr);
          pending <= 1'b0;
        end else begin
          pending  <= 1'b1;
          waitLeft <= waitNow - 1;
        end
      end
    end
  end

endmodule

// ==== bench/insFetch_assertions.sv ====
// Concurrent checks for the fetch front end, attached with bind.
// Bus rules are watched on fetchMaster, the output handshake on insAligner.
// Each bind ties the ports it does not use to their idle values.

module insFetch_assertions (
  input logic              clk,
  input logic              rst,
  input logic              cyc,
  input logic              stb,
  input logic [31:0]       adr,
  input logic              ack,
  input logic              insValid,
  input logic              insReady,
  input insPkg::fetchedIns ins
);

  timeunit 1ns;
  timeprecision 1ps;

  // ==================================================
  // Wishbone classic rules
  // ==================================================

  stbNeedsCyc: assert property (@(posedge clk) disable iff (rst) stb |-> cyc)
    else $error("Bus strobe raised without an active cycle");

  // Request stays up with the same address until the slave acks
  adrHeld: assert property (@(posedge clk) disable iff (rst)
    (stb && !ack) |=> (stb && $stable(adr)))
    else $error("Bus request changed or dropped before its ack");

  // At least one idle cycle between reads
  stbGap: assert property (@(posedge clk) disable iff (rst) (stb && ack) |=> !stb)
    else $error("Bus strobe not dropped after an ack");

  // ==================================================
  // Output handshake and reset state
  // ==================================================

  insHeld: assert property (@(posedge clk) disable iff (rst)
    (insValid && !insReady) |=> (insValid && $stable(ins)))
    else $error("Instruction output changed while waiting on ready");

  resetQuiet: assert property (@(posedge clk) rst |=> (!insValid && !cyc && !stb))
    else $error("Valid or bus request active right after reset");

endmodule

bind fetchMaster insFetch_assertions busChecks (
  .clk      (clk),
  .rst      (rst),
  .cyc      (wbOut.cyc),
  .stb      (wbOut.stb),
  .adr      (wbOut.adr),
  .ack      (wbIn.ack),
  .insValid (1'b0),
  .insReady (1'b1),
  .ins      ('0)
);

bind insAligner insFetch_assertions outChecks (
  .clk      (clk),
  .rst      (rst),
  .cyc      (1'b0),
  .stb      (1'b0),
  .adr      (32'h0),
  .ack      (1'b0),
  .insValid (insValid),
  .insReady (insReady),
  .ins      (ins)
);

// ==== bench/insFetchTb.sv ====
// Testbench for the instruction fetch front end.
// Builds a random program of back to back instructions, walks it with its
// own length table to get the expected stream, and checks every transfer
// on the output while ready is randomly held low. Run with the Makefile.

module insFetchTb;

  timeunit 1ns;
  timeprecision 1ps;

  import insPkg::*;
  import busPkg::*;

  localparam int          numIns    = 300;
  localparam int          memWords  = 256;
  localparam int          memBytes  = memWords * 4;
  localparam int          clkPeriod = 20;
  localparam logic [31:0] resetAddr = 32'h0;

  logic       clk;
  logic       rst;
  logic       insReady;
  logic       insValid;
  fetchedIns  ins;
  wbReq       wbOut;
  wbRsp       wbIn;
  logic [7:0] image [memBytes];
  fetchedIns  expQ [$];
  int         doneCount;

  insFetchTop #(
    .resetAddr  (resetAddr),
    .queueDepth (16)
  ) DUT (
    .clk      (clk),
    .rst      (rst),
    .wbOut    (wbOut),
    .wbIn     (wbIn),
    .insValid (insValid),
    .ins      (ins),
    .insReady (insReady)
  );

  insMemModel #(
    .numWords (memWords)
  ) imem (
    .clk (clk),
    .rst (rst),
    .req (wbOut),
    .rsp (wbIn)
  );

  // ==================================================
  // Reference model
  // ==================================================

  // Length from the first byte and the extension bit, groups first
  function automatic int refLen(input logic [7:0] op, input logic v);
    case (op[7:4])
      4'h2: return 5;
      4'h3: return 7;
      4'h8, 4'h9: return v ? 6 : 1;
      default: ;
    endcase
    case (op)
      BRK, NOP, RTS:   return 2;
      SYS, MOV:        return 3;
      ADDI, ANDI, ORI: return 4;
      CSR:             return 5;
      ADDIL:           return 7;
      CHKI, BMAPI:     return 8;
      default:         return 1;
    endcase
  endfunction

  // Program image repeats every memBytes, the same as the memory model
  function automatic logic [7:0] byteAt(input logic [31:0] a);
    return image[a[$clog2(memBytes)-1:0]];
  endfunction

  function automatic void buildExpected(input int n);
    logic [31:0] pc;
    logic [7:0]  second;
    int          len;
    fetchedIns   e;
    pc = resetAddr;
    for (int i = 0; i < n; i++) begin
      second  = byteAt(pc + 32'd1);
      len     = refLen(byteAt(pc), second[7]);
      e.addr  = pc;
      e.len   = 4'(len);
      e.bytes = '0;
      for (int k = 0; k < len; k++) begin
        e.bytes[8*k +: 8] = byteAt(pc + 32'(k));
      end
      expQ.push_back(e);
      pc = pc + 32'(len);
    end
  endfunction

  // ==================================================
  // Program generation
  // ==================================================

  function automatic logic [7:0] pickOpcode();
    opcode listed [12];
    int    pick;
    listed = '{BRK, NOP, RTS, ADDI, ADDIL, ANDI, ORI, CSR, MOV, SYS, CHKI, BMAPI};
    pick   = int'($urandom_range(15, 0));
    if (pick < 12) begin
      return listed[pick];
    end else if (pick == 12) begin
      return {4'h2, 4'($urandom())};
    end else if (pick == 13) begin
      return {4'h3, 4'($urandom())};
    end else if (pick == 14) begin
      return {3'b100, 5'($urandom())};
    end else begin
      return 8'($urandom());
    end
  endfunction

  // Bytes at the end that do not fit a whole instruction are left random
  function automatic void genProgram();
    logic [7:0] op;
    logic [7:0] second;
    int         pos;
    int         len;
    for (int i = 0; i < memBytes; i++) begin
      image[i] = 8'($urandom());
    end
    pos = 0;
    while (pos < memBytes) begin
      op     = pickOpcode();
      second = 8'($urandom());
      len    = refLen(op, second[7]);
      for (int k = 0; k < len; k++) begin
        if (pos + k < memBytes) begin
          image[pos+k] = (k == 0) ? op : ((k == 1) ? second : 8'($urandom()));
        end
      end
      pos += len;
    end
  endfunction

  task automatic loadMemory();
    for (int w = 0; w < memWords; w++) begin
      imem.loadWord(w, {image[4*w+3], image[4*w+2], image[4*w+1], image[4*w]});
    end
  endtask

  // ==================================================
  // Checking
  // ==================================================

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] actual,
                            input logic [63:0] expected);
    if (actual !== expected) begin
      failRun($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  // Fetch addresses must climb by one word from resetAddr with no gaps
  task automatic checkAccessLog();
    int n;
    n = imem.accessLog.size();
    if (n == 0) begin
      failRun("No bus reads were seen during the run");
    end else begin
      for (int i = 0; i < n; i++) begin
        checkValue("wbOut.adr", 64'(imem.accessLog[i]), 64'(resetAddr + 32'(4 * i)));
      end
    end
  endtask

  // ==================================================
  // Processes
  // ==================================================

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin : mainSeq
    void'($urandom(32'hab37_e7b3));
    rst      = 1'b1;
    insReady = 1'b0;
    genProgram();
    loadMemory();
    buildExpected(numIns);
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    wait (doneCount == numIns);
    checkAccessLog();
    $display("Regression passed");
    $finish;
  end

  // Ready goes low for stretches long enough to fill the queue
  initial begin : readyDriver
    int holdLeft;
    holdLeft = 0;
    wait (rst === 1'b0);
    forever begin
      @(posedge clk);
      if (holdLeft > 0) begin
        holdLeft--;
      end else if ($urandom_range(3, 0) == 0) begin
        insReady <= 1'b0;
        holdLeft = int'($urandom_range(12, 1));
      end else begin
        insReady <= 1'b1;
        holdLeft = int'($urandom_range(4, 0));
      end
    end
  end

  // One expectation per transfer, sampled on the edge that completes it
  initial begin : compare
    fetchedIns expected;
    doneCount = 0;
    forever begin
      @(posedge clk);
      if (rst === 1'b0 && insValid && insReady) begin
        if (expQ.size() == 0) begin
          failRun("The DUT sent more instructions than the reference expects");
        end else begin
          expected = expQ.pop_front();
          checkValue("ins.addr", 64'(ins.addr), 64'(expected.addr));
          checkValue("ins.len", 64'(ins.len), 64'(expected.len));
          checkValue("ins.bytes beyond len", ins.bytes >> (8 * int'(ins.len)), 64'h0);
          checkValue("ins.bytes", ins.bytes, expected.bytes);
          doneCount++;
        end
      end
    end
  end

  // Every fetch is a full-word read with we held low
  initial begin : busFields
    forever begin
      @(posedge clk);
      if (rst === 1'b0 && wbOut.cyc) begin
        checkValue("wbOut.we", 64'(wbOut.we), 64'h0);
        checkValue("wbOut.sel", 64'(wbOut.sel), 64'hf);
      end
    end
  end

  initial begin : watchdog
    #((200 * numIns + 500) * clkPeriod);
    failRun("Timeout: the instruction stream stalled before all instructions arrived");
  end

endmodule

// ==== list.f ====
verilog/insPkg.sv
verilog/busPkg.sv
verilog/insLength.sv
verilog/byteQueue.sv
verilog/fetchMaster.sv
verilog/insAligner.sv
verilog/insFetchTop.sv
bench/insMemModel.sv
bench/insFetch_assertions.sv
bench/insFetchTb.sv

// ==== Makefile ====
# Verilator build for the instruction fetch front end and its testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = insFetchTb
FILELIST = list.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
